/* compile.f */
logic/rv_pkg.sv
logic/fwd_if.sv
logic/pipe_reg.sv
logic/reg_file.sv
logic/alu.sv
logic/forward_unit.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/rv_core.sv
sim/tb_clock.sv
sim/rv_core_checker.sv
sim/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/fwd_if.sv
  - logic/pipe_reg.sv
  - logic/reg_file.sv
  - logic/alu.sv
  - logic/forward_unit.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/rv_core.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/rv_core_checker.sv
      - sim/rv_core_tb.sv

/* sim/rv_core_tb.sv */
`default_nettype none

module rv_core_tb;

  timeunit 1ns;
  timeprecision 100ps;

  logic                          clk;
  logic                          rst_n;
  logic [rv_pkg::XLEN-1:0]       inst;
  logic [rv_pkg::XLEN-1:0]       pc;
  logic                          retire_valid;
  logic [rv_pkg::REG_ADDR_W-1:0] retire_rd;
  logic [rv_pkg::XLEN-1:0]       retire_data;
  logic [3:0]                    test_id;
  logic                          done;
  int                            error_count;
  integer                        seed;

  // program image, with the test each word belongs to
  logic [rv_pkg::XLEN-1:0] prog [$];
  logic [3:0]              prog_test [$];

  tb_clock clock_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  rv_core dut_i (
    .clk            (clk),
    .rst_n_i        (rst_n),
    .inst_i         (inst),
    .pc_o           (pc),
    .retire_valid_o (retire_valid),
    .retire_rd_o    (retire_rd),
    .retire_data_o  (retire_data)
  );

  rv_core_checker checker_i (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .pc_i           (pc),
    .inst_i         (inst),
    .test_id_i      (test_id),
    .retire_valid_i (retire_valid),
    .retire_rd_i    (retire_rd),
    .retire_data_i  (retire_data),
    .done_o         (done),
    .error_count_o  (error_count)
  );

  function logic [31:0] next_random();
    return $random(seed);
  endfunction

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  task automatic emit(input logic [31:0] word, input logic [3:0] test);
    prog.push_back(word);
    prog_test.push_back(test);
  endtask

  // ======================================================================
  // program image
  // ======================================================================
  task automatic build_program();
    int          i;
    logic [31:0] r;
    logic [11:0] imm;
    logic [6:0]  f7;
    for (i = 1; i < 16; i++) begin
      r = next_random();
      emit(u_word(r[31:12], i[4:0], rv_pkg::OPC_LUI), 4'd1);
      emit(i_word(r[11:0], i[4:0], 3'b000, i[4:0]), 4'd1);
    end
    // random alu ops, bit 19 picks register or immediate form
    for (i = 0; i < 40; i++) begin
      r   = next_random();
      imm = r[31:20];
      f7  = (r[3] && (r[2:0] == 3'b000 || r[2:0] == 3'b101)) ? 7'b0100000 : 7'b0000000;
      if (r[19]) begin
        emit(r_word(f7, r[18:14], r[13:9], r[2:0], r[8:4]), 4'd1);
      end else begin
        if (r[2:0] == 3'b001) begin
          imm = {7'b0000000, imm[4:0]};
        end else if (r[2:0] == 3'b101) begin
          imm = {f7, imm[4:0]};
        end
        emit(i_word(imm, r[13:9], r[2:0], r[8:4]), 4'd1);
      end
    end

    // producer x20, then 0 to 2 fillers, then a consumer
    for (i = 0; i < 12; i++) begin
      r = next_random();
      emit(i_word(r[11:0], 5'd20, 3'b000, 5'd20), 4'd2);
      if (i % 3 >= 1) emit(i_word(r[23:12], 5'd4, 3'b100, 5'd21), 4'd2);
      if (i % 3 == 2) emit(i_word(r[31:20], 5'd5, 3'b110, 5'd22), 4'd2);
      f7 = i[1] ? 7'b0100000 : 7'b0000000;
      emit(r_word(f7, 5'd20, i[0] ? 5'd20 : 5'd3, 3'b000, 5'd23), 4'd2);
    end
    // memory stage must win over writeback
    emit(i_word(12'h123, 5'd20, 3'b000, 5'd20), 4'd2);
    emit(i_word(12'h7f0, 5'd20, 3'b000, 5'd20), 4'd2);
    emit(r_word(7'b0000000, 5'd0, 5'd20, 3'b000, 5'd24), 4'd2);

    for (i = 0; i < 6; i++) begin
      r = next_random();
      emit(u_word(r[31:12], 5'd26 + 5'(i % 3), rv_pkg::OPC_AUIPC), 4'd3);
      emit(i_word(12'd1, 5'd26 + 5'(i % 3), 3'b000, 5'd29), 4'd3);
    end

    r = next_random();
    emit(i_word(r[11:0], 5'd0, 3'b000, 5'd0), 4'd4);
    emit(r_word(7'b0000000, 5'd0, 5'd0, 3'b000, 5'd9), 4'd4);
    emit(r_word(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd0), 4'd4);
    emit(i_word(r[23:12], 5'd0, 3'b110, 5'd10), 4'd4);
    // store, branch and jal opcodes are not decoded here
    emit({r[31:7], 7'b0100011}, 4'd4);
    emit({r[24:0], 7'b1100011}, 4'd4);
    emit({r[30:6], 7'b1101111}, 4'd4);
    emit(r_word(7'b0100000, 5'd9, 5'd0, 3'b000, 5'd11), 4'd4);
  endtask

  // fetch for the pc the core will present after this edge
  always @(posedge clk) begin : fetch_driver
    logic [31:0] next_pc;
    next_pc = rst_n ? pc + 32'd4 : 32'd0;
    if (next_pc[31:2] < prog.size()) begin
      inst    <= prog[next_pc[31:2]];
      test_id <= prog_test[next_pc[31:2]];
    end else begin
      // test 0 marks the nops past the end
      inst    <= rv_pkg::NOP_INST;
      test_id <= 4'd0;
    end
  end

  initial begin : run_control
    int limit;
    int cycles;
    seed    = 32'hc3e4;
    inst    = rv_pkg::NOP_INST;
    test_id = 4'd0;
    build_program();
    limit  = prog.size() + 20;
    cycles = 0;
    while (done !== 1'b1 && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (done !== 1'b1) begin
      $display("timeout: retirements still outstanding after %0d cycles", cycles);
      $display("Test failed");
    end else if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/rv_core_checker.sv */
`default_nettype none

module rv_core_checker (
  input  wire                          clk_i,
  input  wire                          rst_n_i,
  input  wire [rv_pkg::XLEN-1:0]       pc_i,
  input  wire [rv_pkg::XLEN-1:0]       inst_i,
  input  wire [3:0]                    test_id_i,
  input  wire                          retire_valid_i,
  input  wire [rv_pkg::REG_ADDR_W-1:0] retire_rd_i,
  input  wire [rv_pkg::XLEN-1:0]       retire_data_i,
  output logic                         done_o,
  output int                           error_count_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // sampling edge to the edge where the retirement is seen
  localparam int LATENCY = 5;
  localparam int TIMING  = 5;

  typedef struct packed {
    int          cycle;
    int          test;
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] pc;
  } expect_t;

  expect_t     pending [$];
  logic [31:0] model_regs [32];
  int          checks [6];
  int          errors [6];
  int          total_errors;
  int          cycle;
  int          reset_edges;
  int          cur_test;
  logic        finished;

  assign error_count_o = total_errors;

  initial begin
    done_o       = 1'b0;
    finished     = 1'b0;
    total_errors = 0;
    cycle        = 0;
    reset_edges  = 0;
    cur_test     = 0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    for (int i = 0; i < 6; i++) begin
      checks[i] = 0;
      errors[i] = 0;
    end
  end

  // ======================================================================
  // instruction set model
  // ======================================================================
  function automatic logic writes_rd(input logic [31:0] inst);
    case (inst[6:0])
      rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM,
      rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: return inst[11:7] != 5'd0;
      default:                            return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] ref_result(input logic [31:0] pc, input logic [31:0] inst,
                                             input logic [31:0] a, input logic [31:0] rs2_val);
    logic [31:0] b;
    logic [31:0] imm_u;
    logic [4:0]  sh;
    imm_u = {inst[31:12], 12'h000};
    if (inst[6:0] == rv_pkg::OPC_LUI) return imm_u;
    if (inst[6:0] == rv_pkg::OPC_AUIPC) return pc + imm_u;
    b  = (inst[6:0] == rv_pkg::OPC_OP) ? rs2_val : {{20{inst[31]}}, inst[31:20]};
    sh = b[4:0];
    case (inst[14:12])
      3'b000:  return (inst[6:0] == rv_pkg::OPC_OP && inst[30]) ? a - b : a + b;
      3'b001:  return a << sh;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101: begin
        if (inst[30]) return $signed(a) >>> sh;
        return a >> sh;
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic string test_label(input int t);
    case (t)
      0:       return "reset";
      1:       return "alu ops";
      2:       return "forwarding";
      3:       return "auipc";
      4:       return "bubbles and x0";
      default: return "timing";
    endcase
  endfunction

  task automatic tally(input int t, input logic ok);
    checks[t]++;
    if (!ok) begin
      errors[t]++;
      total_errors++;
    end
  endtask

  task automatic report_test(input int t);
    $display("%s: %0d checks, %0d errors", test_label(t), checks[t], errors[t]);
  endtask

  // ======================================================================
  // comparison
  // ======================================================================
  always @(posedge clk_i) begin : watch
    expect_t e;
    expect_t due;
    logic    have_due;
    int      sum;
    if (!finished && !rst_n_i) begin
      if (reset_edges > 0) begin
        tally(0, retire_valid_i === 1'b0);
        if (retire_valid_i !== 1'b0) $display("retirement reported during reset");
      end
      reset_edges++;
      cycle = 0;
    end else if (!finished) begin
      e.cycle = cycle;
      e.test  = test_id_i;
      e.pc    = cycle * 4;
      tally((cycle < LATENCY) ? 0 : TIMING, pc_i === e.pc);
      if (pc_i !== e.pc) $display("ERROR pc_o: got %h, expected %h", pc_i, e.pc);
      e.valid = writes_rd(inst_i);
      e.rd    = inst_i[11:7];
      e.data  = ref_result(e.pc, inst_i, model_regs[inst_i[19:15]], model_regs[inst_i[24:20]]);
      if (e.valid) model_regs[e.rd] = e.data;
      pending.push_back(e);

      have_due = 1'b0;
      if (pending.size() > 0 && pending[0].cycle == cycle - LATENCY) begin
        due      = pending.pop_front();
        have_due = 1'b1;
      end
      if (have_due && due.test != cur_test) begin
        if (cur_test > 0) report_test(cur_test);
        cur_test = due.test;
      end

      if (have_due && due.test == 0) begin
        // first nop past the program, everything before it is compared
        report_test(TIMING);
        sum = 0;
        for (int i = 0; i < 6; i++) sum += checks[i];
        $display("total: %0d checks, %0d errors", sum, total_errors);
        finished = 1'b1;
        done_o  <= 1'b1;
      end else if (!have_due) begin
        tally(0, retire_valid_i === 1'b0);
        if (retire_valid_i !== 1'b0) $display("retirement reported before the pipeline filled");
      end else if (due.valid) begin
        tally(TIMING, retire_valid_i === 1'b1);
        if (retire_valid_i !== 1'b1) begin
          $display("missing retirement for the instruction at pc %h", due.pc);
        end else begin
          tally(due.test, retire_rd_i === due.rd);
          if (retire_rd_i !== due.rd) begin
            $display("ERROR retire_rd_o: got %h, expected %h (pc %h)",
                     retire_rd_i, due.rd, due.pc);
          end
          tally(due.test, retire_data_i === due.data);
          if (retire_data_i !== due.data) begin
            $display("ERROR retire_data_o: got %h, expected %h (pc %h)",
                     retire_data_i, due.data, due.pc);
          end
        end
      end else begin
        tally(due.test, retire_valid_i === 1'b0);
        if (retire_valid_i !== 1'b0) begin
          $display("unexpected retirement of x%0d for the bubble at pc %h", retire_rd_i, due.pc);
        end
      end

      if (cycle == LATENCY - 1) report_test(0);
      cycle++;
    end
  end

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // reset released on an edge, like every other input
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

/* logic/rv_core.sv */
`default_nettype none

module rv_core (
  input  wire                             clk,
  input  wire                             rst_n_i,
  input  wire [rv_pkg::XLEN-1:0]          inst_i,
  output logic [rv_pkg::XLEN-1:0]         pc_o,
  output logic                            retire_valid_o,
  output logic [rv_pkg::REG_ADDR_W-1:0]   retire_rd_o,
  output logic [rv_pkg::XLEN-1:0]         retire_data_o
);

  logic [rv_pkg::XLEN-1:0] pc_q;
  rv_pkg::if_id_t          if_id_d;
  rv_pkg::if_id_t          if_id_q;
  rv_pkg::id_exe_t         id_exe_d;
  rv_pkg::id_exe_t         id_exe_q;
  rv_pkg::exe_mem_t        exe_mem_d;
  rv_pkg::exe_mem_t        exe_mem_q;
  logic [rv_pkg::XLEN-1:0] mem_result;
  rv_pkg::mem_wb_t         mem_wb_d;
  rv_pkg::mem_wb_t         mem_wb_q;
  logic [rv_pkg::XLEN-1:0] wb_data;

  fwd_if fwd_bus ();

  // ======================================================================
  // fetch
  // ======================================================================
  // straight-line fetch, no branches
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_q + 32'd4;
    end
  end

  assign pc_o    = pc_q;
  assign if_id_d = '{pc: pc_q, inst: inst_i};

  pipe_reg #(.payload_t(rv_pkg::if_id_t), .CLR_VALUE(rv_pkg::IF_ID_CLR)) if_id_reg_i (
    .clk(clk), .rst_n_i(rst_n_i), .en_i(1'b1), .d_i(if_id_d), .q_o(if_id_q)
  );

  // ======================================================================
  // decode / execute
  // ======================================================================
  decode_stage decode_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .if_id_i   (if_id_q),
    .wb_data_i (wb_data),
    .fwd       (fwd_bus),
    .id_exe_o  (id_exe_d)
  );

  pipe_reg #(.payload_t(rv_pkg::id_exe_t)) id_exe_reg_i (
    .clk(clk), .rst_n_i(rst_n_i), .en_i(1'b1), .d_i(id_exe_d), .q_o(id_exe_q)
  );

  execute_stage execute_i (
    .id_exe_i     (id_exe_q),
    .mem_result_i (mem_result),
    .wb_result_i  (wb_data),
    .fwd_a_i      (fwd_bus.fwd_a),
    .fwd_b_i      (fwd_bus.fwd_b),
    .exe_mem_o    (exe_mem_d)
  );

  pipe_reg #(.payload_t(rv_pkg::exe_mem_t)) exe_mem_reg_i (
    .clk(clk), .rst_n_i(rst_n_i), .en_i(1'b1), .d_i(exe_mem_d), .q_o(exe_mem_q)
  );

  // ======================================================================
  // memory slot and writeback
  // ======================================================================
  // lui bypasses the alu result
  assign mem_result = exe_mem_q.lui ? exe_mem_q.imm : exe_mem_q.alu_result;
  assign mem_wb_d   = '{result: mem_result, rd: exe_mem_q.rd, reg_write: exe_mem_q.reg_write};

  pipe_reg #(.payload_t(rv_pkg::mem_wb_t)) mem_wb_reg_i (
    .clk(clk), .rst_n_i(rst_n_i), .en_i(1'b1), .d_i(mem_wb_d), .q_o(mem_wb_q)
  );

  assign wb_data = mem_wb_q.result;

  // hazard info for the forwarding unit
  assign fwd_bus.rs1_exe = id_exe_q.rs1;
  assign fwd_bus.rs2_exe = id_exe_q.rs2;
  assign fwd_bus.rd_mem  = exe_mem_q.rd;
  assign fwd_bus.we_mem  = exe_mem_q.reg_write;
  assign fwd_bus.rd_wb   = mem_wb_q.rd;
  assign fwd_bus.we_wb   = mem_wb_q.reg_write;

  forward_unit forward_i (
    .fwd (fwd_bus)
  );

  // retirement is reported the cycle after the register write
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      retire_valid_o <= 1'b0;
    end else begin
      retire_valid_o <= mem_wb_q.reg_write && (mem_wb_q.rd != '0);
    end
  end

  always_ff @(posedge clk) begin
    retire_rd_o   <= mem_wb_q.rd;
    retire_data_o <= mem_wb_q.result;
  end

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`default_nettype none

module execute_stage (
  input  wire rv_pkg::id_exe_t   id_exe_i,
  input  wire [rv_pkg::XLEN-1:0] mem_result_i,
  input  wire [rv_pkg::XLEN-1:0] wb_result_i,
  input  wire [1:0]              fwd_a_i,
  input  wire [1:0]              fwd_b_i,
  output rv_pkg::exe_mem_t       exe_mem_o
);

  logic [rv_pkg::XLEN-1:0] rs1_val;
  logic [rv_pkg::XLEN-1:0] rs2_val;
  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [rv_pkg::XLEN-1:0] alu_result;

  // 3-way forwarding mux
  function automatic logic [rv_pkg::XLEN-1:0] pick(input logic [1:0]              sel,
                                                   input logic [rv_pkg::XLEN-1:0] reg_val,
                                                   input logic [rv_pkg::XLEN-1:0] mem_val,
                                                   input logic [rv_pkg::XLEN-1:0] wb_val);
    case (sel)
      rv_pkg::FWD_MEM: return mem_val;
      rv_pkg::FWD_WB:  return wb_val;
      default:         return reg_val;
    endcase
  endfunction

  assign rs1_val = pick(fwd_a_i, id_exe_i.rs1_data, mem_result_i, wb_result_i);
  assign rs2_val = pick(fwd_b_i, id_exe_i.rs2_data, mem_result_i, wb_result_i);

  // pc feeds operand a only for auipc
  assign op_a = id_exe_i.pc_src  ? id_exe_i.pc  : rs1_val;
  assign op_b = id_exe_i.imm_src ? id_exe_i.imm : rs2_val;

  alu alu_i (
    .op_i     (id_exe_i.alu_op),
    .a_i      (op_a),
    .b_i      (op_b),
    .result_o (alu_result)
  );

  always_comb begin
    exe_mem_o.alu_result = alu_result;
    exe_mem_o.imm        = id_exe_i.imm;
    exe_mem_o.rd         = id_exe_i.rd;
    exe_mem_o.reg_write  = id_exe_i.reg_write;
    exe_mem_o.lui        = id_exe_i.lui;
  end

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`default_nettype none

module decode_stage (
  input  wire                    clk,
  input  wire                    rst_n_i,
  input  wire rv_pkg::if_id_t    if_id_i,
  input  wire [rv_pkg::XLEN-1:0] wb_data_i,
  fwd_if.pipeline                fwd,
  output rv_pkg::id_exe_t        id_exe_o
);

  logic [rv_pkg::XLEN-1:0] inst;
  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic                    funct7_5;
  logic [rv_pkg::XLEN-1:0] rdata_a;
  logic [rv_pkg::XLEN-1:0] rdata_b;
  logic [rv_pkg::XLEN-1:0] imm;
  rv_pkg::alu_op_e         alu_op;
  logic                    reg_write;
  logic                    imm_src;
  logic                    pc_src;
  logic                    lui;

  // funct3 to alu op, alt picks sub or sra
  function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  return rv_pkg::ALU_SLL;
      3'b010:  return rv_pkg::ALU_SLT;
      3'b011:  return rv_pkg::ALU_SLTU;
      3'b100:  return rv_pkg::ALU_XOR;
      3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  return rv_pkg::ALU_OR;
      default: return rv_pkg::ALU_AND;
    endcase
  endfunction

  assign inst     = if_id_i.inst;
  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign funct7_5 = inst[30];

  // sources out to the forwarding unit
  assign fwd.rs1_id = inst[19:15];
  assign fwd.rs2_id = inst[24:20];

  // ======================================================================
  // control decode
  // ======================================================================
  always_comb begin
    reg_write = 1'b1;
    imm_src   = 1'b0;
    pc_src    = 1'b0;
    lui       = 1'b0;
    alu_op    = rv_pkg::ALU_ADD;
    case (opcode)
      rv_pkg::OPC_OP: begin
        alu_op = arith_op(funct3, funct7_5);
      end
      rv_pkg::OPC_OP_IMM: begin
        // no subi, only srai uses bit 30
        imm_src = 1'b1;
        alu_op  = arith_op(funct3, (funct3 == 3'b101) && funct7_5);
      end
      rv_pkg::OPC_LUI: begin
        imm_src = 1'b1;
        lui     = 1'b1;
        alu_op  = rv_pkg::ALU_PASS_B;
      end
      rv_pkg::OPC_AUIPC: begin
        imm_src = 1'b1;
        pc_src  = 1'b1;
      end
      // anything else becomes a bubble
      default: reg_write = 1'b0;
    endcase
  end

  // u-type for lui/auipc, i-type otherwise
  assign imm = (opcode == rv_pkg::OPC_LUI || opcode == rv_pkg::OPC_AUIPC) ?
               {inst[31:12], 12'b0} : {{20{inst[31]}}, inst[31:20]};

  reg_file reg_file_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .we_i      (fwd.we_wb),
    .waddr_i   (fwd.rd_wb),
    .wdata_i   (wb_data_i),
    .raddr_a_i (inst[19:15]),
    .raddr_b_i (inst[24:20]),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  always_comb begin
    id_exe_o.pc        = if_id_i.pc;
    // writeback bypass for a write landing this same cycle
    id_exe_o.rs1_data  = fwd.fwd_id_a ? wb_data_i : rdata_a;
    id_exe_o.rs2_data  = fwd.fwd_id_b ? wb_data_i : rdata_b;
    id_exe_o.imm       = imm;
    id_exe_o.rs1       = inst[19:15];
    id_exe_o.rs2       = inst[24:20];
    id_exe_o.rd        = inst[11:7];
    id_exe_o.reg_write = reg_write;
    id_exe_o.alu_op    = alu_op;
    id_exe_o.imm_src   = imm_src;
    id_exe_o.pc_src    = pc_src;
    id_exe_o.lui       = lui;
  end

endmodule

`default_nettype wire

/* logic/forward_unit.sv */
`default_nettype none

module forward_unit (
  fwd_if.unit fwd
);

  // producer writes a real register that matches the source
  function automatic logic hit(input logic                          we,
                               input logic [rv_pkg::REG_ADDR_W-1:0] rd,
                               input logic [rv_pkg::REG_ADDR_W-1:0] rs);
    return we && (rd != '0) && (rd == rs);
  endfunction

  // execute selects, memory stage wins over writeback
  always_comb begin
    fwd.fwd_a = rv_pkg::FWD_REG;
    if (hit(fwd.we_mem, fwd.rd_mem, fwd.rs1_exe)) begin
      fwd.fwd_a = rv_pkg::FWD_MEM;
    end else if (hit(fwd.we_wb, fwd.rd_wb, fwd.rs1_exe)) begin
      fwd.fwd_a = rv_pkg::FWD_WB;
    end

    fwd.fwd_b = rv_pkg::FWD_REG;
    if (hit(fwd.we_mem, fwd.rd_mem, fwd.rs2_exe)) begin
      fwd.fwd_b = rv_pkg::FWD_MEM;
    end else if (hit(fwd.we_wb, fwd.rd_wb, fwd.rs2_exe)) begin
      fwd.fwd_b = rv_pkg::FWD_WB;
    end
  end

  // decode only ever needs the writeback value
  assign fwd.fwd_id_a = hit(fwd.we_wb, fwd.rd_wb, fwd.rs1_id);
  assign fwd.fwd_id_b = hit(fwd.we_wb, fwd.rd_wb, fwd.rs2_id);

endmodule

`default_nettype wire

/* logic/alu.sv */
`default_nettype none

module alu (
  input  wire rv_pkg::alu_op_e    op_i,
  input  wire [rv_pkg::XLEN-1:0]  a_i,
  input  wire [rv_pkg::XLEN-1:0]  b_i,
  output logic [rv_pkg::XLEN-1:0] result_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b_i[4:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      rv_pkg::ALU_ADD:    result_o = a_i + b_i;
      rv_pkg::ALU_SUB:    result_o = a_i - b_i;
      rv_pkg::ALU_SLL:    result_o = a_i << shamt;
      // set-less-than results are zero extended
      rv_pkg::ALU_SLT:    result_o = {{(rv_pkg::XLEN-1){1'b0}}, lt_signed};
      rv_pkg::ALU_SLTU:   result_o = {{(rv_pkg::XLEN-1){1'b0}}, lt_unsigned};
      rv_pkg::ALU_XOR:    result_o = a_i ^ b_i;
      rv_pkg::ALU_SRL:    result_o = a_i >> shamt;
      rv_pkg::ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
      rv_pkg::ALU_OR:     result_o = a_i | b_i;
      rv_pkg::ALU_AND:    result_o = a_i & b_i;
      rv_pkg::ALU_PASS_B: result_o = b_i;
      default:            result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none

module reg_file (
  input  wire                           clk,
  input  wire                           rst_n_i,
  input  wire                           we_i,
  input  wire [rv_pkg::REG_ADDR_W-1:0]  waddr_i,
  input  wire [rv_pkg::XLEN-1:0]        wdata_i,
  input  wire [rv_pkg::REG_ADDR_W-1:0]  raddr_a_i,
  input  wire [rv_pkg::REG_ADDR_W-1:0]  raddr_b_i,
  output logic [rv_pkg::XLEN-1:0]       rdata_a_o,
  output logic [rv_pkg::XLEN-1:0]       rdata_b_o
);

  logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NUM_REGS];

  // x0 is never written so it reads zero forever
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // async read ports
  assign rdata_a_o = regs[raddr_a_i];
  assign rdata_b_o = regs[raddr_b_i];

endmodule

`default_nettype wire

/* logic/pipe_reg.sv */
`default_nettype none

module pipe_reg #(
  parameter type      payload_t = logic,
  parameter payload_t CLR_VALUE = '0
) (
  input  wire           clk,
  input  wire           rst_n_i,
  input  wire           en_i,
  input  wire payload_t d_i,
  output payload_t      q_o
);

  // one stage worth of payload, back to the clear value on reset
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      q_o <= CLR_VALUE;
    end else if (en_i) begin
      q_o <= d_i;
    end
  end

endmodule

`default_nettype wire

/* logic/fwd_if.sv */
`default_nettype none

interface fwd_if;
  // source indices seen by decode and execute
  logic [rv_pkg::REG_ADDR_W-1:0] rs1_id;
  logic [rv_pkg::REG_ADDR_W-1:0] rs2_id;
  logic [rv_pkg::REG_ADDR_W-1:0] rs1_exe;
  logic [rv_pkg::REG_ADDR_W-1:0] rs2_exe;
  // producers further down the pipe
  logic [rv_pkg::REG_ADDR_W-1:0] rd_mem;
  logic                          we_mem;
  logic [rv_pkg::REG_ADDR_W-1:0] rd_wb;
  logic                          we_wb;
  // selects
  logic [1:0]                    fwd_a;
  logic [1:0]                    fwd_b;
  logic                          fwd_id_a;
  logic                          fwd_id_b;

  modport pipeline (
    output rs1_id, rs2_id, rs1_exe, rs2_exe, rd_mem, we_mem, rd_wb, we_wb,
    input  fwd_a, fwd_b, fwd_id_a, fwd_id_b
  );

  modport unit (
    input  rs1_id, rs2_id, rs1_exe, rs2_exe, rd_mem, we_mem, rd_wb, we_wb,
    output fwd_a, fwd_b, fwd_id_a, fwd_id_b
  );
endinterface

`default_nettype wire

/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // ======================================================================
  // widths and constants
  // ======================================================================
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // addi x0, x0, 0
  localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;

  // major opcodes kept in this core
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  // execute operand sources
  localparam logic [1:0] FWD_REG = 2'd0;
  localparam logic [1:0] FWD_MEM = 2'd1;
  localparam logic [1:0] FWD_WB  = 2'd2;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // ======================================================================
  // stage payloads
  // ======================================================================
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
  } if_id_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_write;
    alu_op_e               alu_op;
    logic                  imm_src;
    logic                  pc_src;
    logic                  lui;
  } id_exe_t;

  typedef struct packed {
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_write;
    logic                  lui;
  } exe_mem_t;

  typedef struct packed {
    logic [XLEN-1:0]       result;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_write;
  } mem_wb_t;

  // fetch register comes out of reset holding a nop
  localparam if_id_t IF_ID_CLR = '{pc: '0, inst: NOP_INST};

endpackage

`default_nettype wire
